//--- source/eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;
    localparam logic [3:0] CTRL_CODE = 4'b1010; // device type code

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } req_op_e;

    // a repeated start is COND_START issued mid-transaction
    typedef enum logic {
        COND_START,
        COND_STOP
    } cond_cmd_e;

    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_CTRL_W,
        SEQ_ADDR,
        SEQ_DATA_W,
        SEQ_RESTART,
        SEQ_CTRL_R,
        SEQ_DATA_R,
        SEQ_STOP,
        SEQ_RESP
    } seq_state_e;

    typedef struct packed {
        req_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } req_t;

endpackage

//--- source/eeprom_ifs.sv
`timescale 1ns/1ps

interface cond_if;
    import eeprom_pkg::*;

    logic      go;       // one-cycle command strobe
    cond_cmd_e cmd;
    logic      low_mid;
    logic      high_mid;
    logic      pull_low;
    logic      done;

    modport seq (output go, cmd, low_mid, high_mid, input pull_low, done);
    modport engine (input go, cmd, low_mid, high_mid, output pull_low, done);
endinterface

interface byte_if;
    import eeprom_pkg::*;

    logic              go;
    logic              rx_mode;  // 1 = read a byte from the line
    logic [DATA_W-1:0] tx_byte;
    logic              low_mid;
    logic              high_mid;
    logic              sda_in;
    logic              pull_low;
    logic              done;
    logic [DATA_W-1:0] rx_byte;
    logic              ack_ok;

    modport seq (
        output go, rx_mode, tx_byte, low_mid, high_mid, sda_in,
        input  pull_low, done, rx_byte, ack_ok
    );
    modport engine (
        input  go, rx_mode, tx_byte, low_mid, high_mid, sda_in,
        output pull_low, done, rx_byte, ack_ok
    );
endinterface

//--- source/req_queue.sv
`timescale 1ns/1ps

module req_queue #(
    parameter int REQ_DEPTH = 4
) (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             push,
    input  eeprom_pkg::req_t push_req,
    input  logic             pop,
    output eeprom_pkg::req_t head,
    output logic             head_valid
);
    import eeprom_pkg::*;

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    req_t             mem [REQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(REQ_DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign do_push    = push && (count != CNT_W'(REQ_DEPTH)); // full drops the push
    assign do_pop     = pop && head_valid;
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_req;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/bus_condition.sv
`timescale 1ns/1ps

module bus_condition (
    input logic    CLK,
    input logic    RESET,
    cond_if.engine bus
);
    import eeprom_pkg::*;

    typedef enum logic [1:0] {
        C_IDLE,
        C_WAIT_LOW,
        C_WAIT_HIGH
    } cond_state_e;

    cond_state_e state;
    cond_cmd_e   cmd_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= C_IDLE;
            cmd_q        <= COND_START;
            bus.pull_low <= 1'b0;
            bus.done     <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            case (state)
                C_IDLE:
                begin
                    if (bus.go)
                    begin
                        cmd_q <= bus.cmd;
                        state <= C_WAIT_LOW;
                    end
                    else if (bus.low_mid)
                        bus.pull_low <= 1'b0; // hand the line to the byte shifter
                end
                C_WAIT_LOW:
                begin
                    if (bus.low_mid)
                    begin
                        // start releases here, stop pulls low
                        bus.pull_low <= (cmd_q == COND_STOP);
                        state        <= C_WAIT_HIGH;
                    end
                end
                C_WAIT_HIGH:
                begin
                    if (bus.high_mid)
                    begin
                        bus.pull_low <= (cmd_q == COND_START); // edge while scl high
                        bus.done     <= 1'b1;
                        state        <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

endmodule

//--- source/byte_shifter.sv
`timescale 1ns/1ps

module byte_shifter (
    input logic    CLK,
    input logic    RESET,
    byte_if.engine bus
);
    import eeprom_pkg::*;

    typedef enum logic {
        SH_IDLE,
        SH_BUSY
    } shift_state_e;

    shift_state_e      state;
    logic              rx_q;
    logic [3:0]        bit_cnt;   // 0..7 data, 8 ack slot
    logic [DATA_W-1:0] shreg;
    logic              data_slot;

    assign data_slot   = (bit_cnt < 4'd8);
    assign bus.rx_byte = shreg;

    // same register serves both directions, msb first
    always_ff @(posedge CLK)
    begin
        if (state == SH_IDLE && bus.go)
            shreg <= bus.tx_byte;
        else if (state == SH_BUSY && bus.high_mid && data_slot)
            shreg <= {shreg[DATA_W-2:0], bus.sda_in};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= SH_IDLE;
            rx_q         <= 1'b0;
            bit_cnt      <= '0;
            bus.pull_low <= 1'b0;
            bus.done     <= 1'b0;
            bus.ack_ok   <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            case (state)
                SH_IDLE:
                begin
                    if (bus.go)
                    begin
                        rx_q    <= bus.rx_mode;
                        bit_cnt <= '0;
                        state   <= SH_BUSY;
                    end
                end
                SH_BUSY:
                begin
                    // ninth slot always released, also the master nack on reads
                    if (bus.low_mid)
                        bus.pull_low <= !rx_q && data_slot && !shreg[DATA_W-1];
                    if (bus.high_mid)
                    begin
                        if (data_slot)
                            bit_cnt <= bit_cnt + 4'd1;
                        else
                        begin
                            bus.ack_ok <= rx_q || !bus.sda_in; // ack is low
                            bus.done   <= 1'b1;
                            state      <= SH_IDLE;
                        end
                    end
                end
                default: state <= SH_IDLE;
            endcase
        end
    end

endmodule

//--- source/eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer #(
    parameter int CLK_DIV = 2
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  eeprom_pkg::req_t              head,
    input  logic                          head_valid,
    input  logic                          sda_in,
    output logic                          pop,
    output logic                          scl,
    output logic                          sda_oe,
    output logic                          rsp_valid,
    output logic [eeprom_pkg::DATA_W-1:0] rsp_data,
    output logic                          rsp_error,
    cond_if.seq                           cbus,
    byte_if.seq                           bbus
);
    import eeprom_pkg::*;

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    seq_state_e        state;
    seq_state_e        next_state;
    logic [CNT_W-1:0]  q_cnt;
    logic [1:0]        q_idx;     // quarter within the bit slot
    req_t              req_q;
    logic [DATA_W-1:0] rd_data;
    logic              err;
    logic              line_idle;
    logic              c_go;
    cond_cmd_e         c_cmd;
    logic              b_go;
    logic              b_rx;
    logic [DATA_W-1:0] b_tx;

    assign pop       = (state == SEQ_IDLE) && head_valid;
    assign line_idle = (state == SEQ_IDLE) || (state == SEQ_RESP)
                    || (state == SEQ_STOP && cbus.done);
    assign scl       = q_idx[1] || line_idle; // keep scl high after the stop

    assign cbus.low_mid  = (q_idx == 2'd1) && (q_cnt == '0);
    assign cbus.high_mid = (q_idx == 2'd3) && (q_cnt == '0);
    assign bbus.low_mid  = cbus.low_mid;
    assign bbus.high_mid = cbus.high_mid;
    assign bbus.sda_in   = sda_in;
    assign cbus.go       = c_go;
    assign cbus.cmd      = c_cmd;
    assign bbus.go       = b_go;
    assign bbus.rx_mode  = b_rx;
    assign bbus.tx_byte  = b_tx;

    assign sda_oe    = cbus.pull_low || bbus.pull_low;
    assign rsp_valid = (state == SEQ_RESP);
    assign rsp_data  = rd_data;
    assign rsp_error = err;

    // go goes out in the same cycle as the previous done, ahead of the next low_mid
    always_comb
    begin
        next_state = state;
        c_go       = 1'b0;
        c_cmd      = COND_START;
        b_go       = 1'b0;
        b_rx       = 1'b0;
        b_tx       = {CTRL_CODE, req_q.addr[ADDR_W-1:DATA_W], 1'b0}; // control byte, write
        case (state)
            SEQ_IDLE:
            begin
                if (head_valid)
                begin
                    next_state = SEQ_START;
                    c_go       = 1'b1;
                end
            end
            SEQ_START:
            begin
                if (cbus.done)
                begin
                    next_state = SEQ_CTRL_W;
                    b_go       = 1'b1;
                end
            end
            SEQ_RESTART:
            begin
                if (cbus.done)
                begin
                    next_state = SEQ_CTRL_R;
                    b_go       = 1'b1;
                    b_tx[0]    = 1'b1;
                end
            end
            SEQ_CTRL_W, SEQ_ADDR, SEQ_DATA_W, SEQ_CTRL_R, SEQ_DATA_R:
            begin
                if (bbus.done)
                begin
                    if (!bbus.ack_ok || state == SEQ_DATA_W || state == SEQ_DATA_R)
                    begin
                        next_state = SEQ_STOP;
                        c_go       = 1'b1;
                        c_cmd      = COND_STOP;
                    end
                    else if (state == SEQ_CTRL_W)
                    begin
                        next_state = SEQ_ADDR;
                        b_go       = 1'b1;
                        b_tx       = req_q.addr[DATA_W-1:0];
                    end
                    else if (state == SEQ_ADDR && req_q.op == OP_WRITE)
                    begin
                        next_state = SEQ_DATA_W;
                        b_go       = 1'b1;
                        b_tx       = req_q.data;
                    end
                    else if (state == SEQ_ADDR)
                    begin
                        next_state = SEQ_RESTART;
                        c_go       = 1'b1;
                    end
                    else
                    begin
                        next_state = SEQ_DATA_R;
                        b_go       = 1'b1;
                        b_rx       = 1'b1;
                    end
                end
            end
            SEQ_STOP:
            begin
                if (cbus.done)
                    next_state = SEQ_RESP;
            end
            default: next_state = SEQ_IDLE; // SEQ_RESP lasts one cycle
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= SEQ_IDLE;
            q_cnt <= '0;
            q_idx <= '0;
            err   <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (state == SEQ_IDLE)
            begin
                q_cnt <= '0;
                q_idx <= '0;
            end
            else if (q_cnt == CNT_W'(CLK_DIV - 1))
            begin
                q_cnt <= '0;
                q_idx <= q_idx + 2'd1;
            end
            else
                q_cnt <= q_cnt + 1'b1;
            if (pop)
                err <= 1'b0;
            else if (bbus.done && !bbus.ack_ok)
                err <= 1'b1; // sticky for this request
        end
    end

    always_ff @(posedge CLK)
    begin
        if (pop)
        begin
            req_q   <= head;
            rd_data <= '0;
        end
        else if (state == SEQ_DATA_R && bbus.done)
            rd_data <= bbus.rx_byte;
    end

endmodule

//--- source/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top #(
    parameter int REQ_DEPTH = 4,
    parameter int CLK_DIV   = 2
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          req_valid,
    input  eeprom_pkg::req_op_e           req_op,
    input  logic [eeprom_pkg::ADDR_W-1:0] req_addr,
    input  logic [eeprom_pkg::DATA_W-1:0] req_data,
    input  logic                          sda_in,
    output logic                          req_credit,
    output logic                          rsp_valid,
    output logic [eeprom_pkg::DATA_W-1:0] rsp_data,
    output logic                          rsp_error,
    output logic                          scl,
    output logic                          sda_oe
);
    import eeprom_pkg::*;

    req_t push_req;
    req_t head;
    logic head_valid;

    cond_if cbus ();
    byte_if bbus ();

    assign push_req = '{op: req_op, addr: req_addr, data: req_data};

    // each pop frees a queue slot, so it doubles as the host credit
    req_queue #(
        .REQ_DEPTH (REQ_DEPTH)
    ) req_queue_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .push       (req_valid),
        .push_req   (push_req),
        .pop        (req_credit),
        .head       (head),
        .head_valid (head_valid)
    );

    eeprom_sequencer #(
        .CLK_DIV (CLK_DIV)
    ) eeprom_sequencer_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .head       (head),
        .head_valid (head_valid),
        .sda_in     (sda_in),
        .pop        (req_credit),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_error  (rsp_error),
        .cbus       (cbus.seq),
        .bbus       (bbus.seq)
    );

    bus_condition bus_condition_i (
        .CLK   (CLK),
        .RESET (RESET),
        .bus   (cbus.engine)
    );

    byte_shifter byte_shifter_i (
        .CLK   (CLK),
        .RESET (RESET),
        .bus   (bbus.engine)
    );

endmodule

//--- verif/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic nack_all,
    output logic pull_low
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX,
        M_TX_ACK
    } model_state_e;

    logic [DATA_W-1:0] mem [2**ADDR_W];
    model_state_e      state;
    logic              scl_q;
    logic              sda_q;
    logic [3:0]        bit_cnt;
    logic [DATA_W-1:0] shreg;
    logic [1:0]        byte_idx;  // 0 control, 1 address, 2 data
    logic              read_mode;
    logic [2:0]        block;
    logic [ADDR_W-1:0] addr_ptr;

    // line sampled on the falling system clock, away from the DUT's edges
    always @(negedge CLK)
    begin
        if (RESET)
        begin
            state     <= M_IDLE;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            pull_low  <= 1'b0;
            bit_cnt   <= '0;
            byte_idx  <= '0;
            read_mode <= 1'b0;
            block     <= '0;
            addr_ptr  <= '0;
            for (int a = 0; a < 2**ADDR_W; a++)
                mem[a] <= DATA_W'(a) ^ DATA_W'(a >> 3) ^ 8'h5a;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && sda_q && !sda) // start or repeated start
            begin
                state    <= M_RX;
                bit_cnt  <= '0;
                byte_idx <= '0;
                pull_low <= 1'b0;
            end
            else if (scl_q && scl && !sda_q && sda) // stop
            begin
                state    <= M_IDLE;
                pull_low <= 1'b0;
            end
            else if (!scl_q && scl)
            begin
                if (state == M_RX)
                begin
                    shreg   <= {shreg[DATA_W-2:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end
                else if (state == M_TX_ACK)
                    state <= M_IDLE; // single read only, wait for the stop
            end
            else if (scl_q && !scl)
            begin
                case (state)
                    M_RX:
                    begin
                        if (bit_cnt == 4'd8)
                        begin
                            if (nack_all || (byte_idx == 2'd0 && shreg[7:4] != CTRL_CODE))
                                state <= M_IDLE; // byte ignored, line stays released
                            else
                            begin
                                pull_low <= 1'b1;
                                state    <= M_ACK;
                                if (byte_idx == 2'd0)
                                begin
                                    read_mode <= shreg[0];
                                    block     <= shreg[3:1];
                                    if (shreg[0])
                                        addr_ptr[ADDR_W-1:DATA_W] <= shreg[3:1];
                                    byte_idx  <= 2'd1;
                                end
                                else if (byte_idx == 2'd1)
                                begin
                                    addr_ptr <= {block, shreg};
                                    byte_idx <= 2'd2;
                                end
                                else
                                begin
                                    mem[addr_ptr] <= shreg;
                                    addr_ptr      <= addr_ptr + 1'b1;
                                end
                            end
                        end
                    end
                    M_ACK:
                    begin
                        if (read_mode)
                        begin
                            pull_low <= !mem[addr_ptr][DATA_W-1];
                            shreg    <= {mem[addr_ptr][DATA_W-2:0], 1'b0};
                            bit_cnt  <= 4'd1;
                            state    <= M_TX;
                        end
                        else
                        begin
                            pull_low <= 1'b0;
                            bit_cnt  <= '0;
                            state    <= M_RX;
                        end
                    end
                    M_TX:
                    begin
                        if (bit_cnt == 4'd8)
                        begin
                            pull_low <= 1'b0; // master's ack slot
                            state    <= M_TX_ACK;
                        end
                        else
                        begin
                            pull_low <= !shreg[DATA_W-1];
                            shreg    <= {shreg[DATA_W-2:0], 1'b0};
                            bit_cnt  <= bit_cnt + 4'd1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- verif/tb_eeprom_ctrl.sv
`timescale 1ns/1ps

module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    localparam int     REQ_DEPTH   = 4;
    localparam int     CLK_DIV     = 2;
    localparam int     READ_CYCLES = 39 * 4 * CLK_DIV; // longest transaction
    localparam int     NUM_ADDR    = 40;
    localparam int     TOTAL_REQS  = 2 + 10 + 2 * NUM_ADDR + 3;
    localparam longint WATCHDOG_NS = longint'(TOTAL_REQS) * READ_CYCLES * 8 + 20000;

    logic              CLK;
    logic              RESET;
    logic              req_valid;
    req_op_e           req_op;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_data;
    logic              sda_in;
    logic              req_credit;
    logic              rsp_valid;
    logic [DATA_W-1:0] rsp_data;
    logic              rsp_error;
    logic              scl;
    logic              sda_oe;
    logic              model_pull;
    logic              nack_all;

    logic [DATA_W-1:0] sb_mem [2**ADDR_W];
    logic              exp_err [$];
    logic              exp_chk [$];
    logic [DATA_W-1:0] exp_data [$];
    logic              got_err [$];
    logic [DATA_W-1:0] got_data [$];
    longint            got_time [$];
    int                credit_pulses = 0;
    int                sent_count = 0;
    bit                credit_fault = 1'b0;
    int                mismatches = 0;
    int                failures = 0;
    logic [31:0]       rng_state = 32'd2816;

    // pull-up, either side may pull low
    assign sda_in = !(sda_oe === 1'b1 || model_pull === 1'b1);

    eeprom_ctrl_top #(
        .REQ_DEPTH (REQ_DEPTH),
        .CLK_DIV   (CLK_DIV)
    ) eeprom_ctrl_top_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .sda_in     (sda_in),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_error  (rsp_error),
        .scl        (scl),
        .sda_oe     (sda_oe)
    );

    eeprom_model eeprom_model_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl      (scl),
        .sda      (sda_in),
        .nack_all (nack_all),
        .pull_low (model_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = !CLK;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with responses still missing", WATCHDOG_NS);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int credit_level();
        return REQ_DEPTH + credit_pulses - sent_count;
    endfunction

    // credits and responses collected where outputs are settled
    always @(negedge CLK)
    begin
        if (!RESET)
        begin
            if (req_credit)
                credit_pulses = credit_pulses + 1;
            if (!credit_fault && (credit_level() < 0 || credit_level() > REQ_DEPTH))
            begin
                $display("host credit count left the range 0 to %0d at %0d ns",
                         REQ_DEPTH, $time);
                failures++;
                credit_fault = 1'b1;
            end
            if (rsp_valid)
            begin
                got_err.push_back(rsp_error);
                got_data.push_back(rsp_data);
                got_time.push_back($time);
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input longint t);
        if (got !== exp)
        begin
            $display("Mismatch at %0d ns: %s expected %0h got %0h", t, name, exp, got);
            mismatches++;
        end
    endtask

    task automatic send_req(input req_op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic expect_err);
        @(posedge CLK); // previous push lands here
        if (credit_level() == 0)
        begin
            @(negedge CLK);
            req_valid = 1'b0;
            while (credit_level() == 0)
                @(posedge CLK);
        end
        @(negedge CLK);
        req_valid  = 1'b1;
        req_op     = op;
        req_addr   = addr;
        req_data   = data;
        sent_count = sent_count + 1;
        exp_err.push_back(expect_err);
        exp_chk.push_back(op == OP_READ && !expect_err);
        exp_data.push_back(sb_mem[addr]);
        if (op == OP_WRITE && !expect_err)
            sb_mem[addr] = data;
    endtask

    task automatic end_reqs();
        @(posedge CLK);
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    task automatic drain_responses();
        int     limit;
        int     waited;
        logic   e;
        logic   c;
        logic   [DATA_W-1:0] d;
        longint t;
        limit  = exp_err.size() * READ_CYCLES + 200;
        waited = 0;
        while (got_err.size() < exp_err.size() && waited < limit)
        begin
            @(posedge CLK);
            waited++;
        end
        if (got_err.size() < exp_err.size())
        begin
            $display("timed out at %0d ns with %0d responses missing", $time,
                     exp_err.size() - got_err.size());
            failures++;
        end
        while (exp_err.size() > 0 && got_err.size() > 0)
        begin
            e = exp_err.pop_front();
            c = exp_chk.pop_front();
            d = exp_data.pop_front();
            t = got_time.pop_front();
            check_val("rsp_error", got_err.pop_front(), e, t);
            if (c)
                check_val("rsp_data", got_data.pop_front(), d, t);
            else
                void'(got_data.pop_front());
        end
        if (got_err.size() > 0)
        begin
            $display("%0d responses arrived with no request behind them", got_err.size());
            failures++;
        end
        exp_err.delete();
        exp_chk.delete();
        exp_data.delete();
        got_err.delete();
        got_data.delete();
        got_time.delete();
    endtask

    task automatic check_idle();
        repeat (4)
        begin
            @(negedge CLK);
            check_val("scl", scl, 1, $time);
            check_val("sda_oe", sda_oe, 0, $time);
            check_val("rsp_valid", rsp_valid, 0, $time);
            check_val("req_credit", req_credit, 0, $time);
        end
    endtask

    task automatic reset_test();
        repeat (5) @(negedge CLK);
        RESET = 1'b0;
        check_idle();
    endtask

    task automatic write_read_test();
        logic [31:0] r;
        r = xorshift32();
        send_req(OP_WRITE, 11'h123, r[7:0], 1'b0);
        send_req(OP_READ, 11'h123, 8'h00, 1'b0);
        end_reqs();
        drain_responses();
    endtask

    task automatic credit_flow_test();
        logic [ADDR_W-1:0] addrs [REQ_DEPTH];
        logic [31:0]       r;
        int                pulses_before;
        int                sent_before;
        pulses_before = credit_pulses;
        sent_before   = sent_count;
        for (int i = 0; i < REQ_DEPTH; i++)
        begin
            r        = xorshift32();
            addrs[i] = {3'(i + 4), r[7:0]};
            send_req(OP_WRITE, addrs[i], r[15:8], 1'b0); // back to back on full credit
        end
        for (int i = 0; i < REQ_DEPTH; i++)
            send_req(OP_READ, addrs[i], 8'h00, 1'b0);
        r = xorshift32();
        send_req(OP_WRITE, addrs[0], r[7:0], 1'b0);
        send_req(OP_READ, addrs[0], 8'h00, 1'b0);
        end_reqs();
        drain_responses();
        check_val("req_credit pulse count", credit_pulses - pulses_before,
                  sent_count - sent_before, $time);
    endtask

    task automatic address_sweep_test();
        logic [ADDR_W-1:0] addrs [NUM_ADDR];
        logic [31:0]       r;
        logic [DATA_W-1:0] offset;
        offset = '0;
        for (int i = 0; i < NUM_ADDR; i++)
        begin
            r = xorshift32();
            if (i % 8 == 0)
                offset = r[23:16];
            addrs[i] = {3'(i % 8), offset}; // same offset in every block
            send_req(OP_WRITE, addrs[i], r[15:8], 1'b0);
        end
        for (int i = 0; i < NUM_ADDR; i++)
            send_req(OP_READ, addrs[i], 8'h00, 1'b0);
        end_reqs();
        drain_responses();
    endtask

    task automatic nack_test();
        logic [31:0] r;
        r        = xorshift32();
        nack_all = 1'b1;
        send_req(OP_WRITE, 11'h2a5, r[7:0], 1'b1);
        send_req(OP_READ, 11'h123, 8'h00, 1'b1);
        end_reqs();
        drain_responses();
        check_idle();
        nack_all = 1'b0;
        send_req(OP_READ, 11'h123, 8'h00, 1'b0);
        end_reqs();
        drain_responses();
    endtask

    initial
    begin
        RESET     = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_WRITE;
        req_addr  = '0;
        req_data  = '0;
        nack_all  = 1'b0;
        reset_test();
        write_read_test();
        credit_flow_test();
        address_sweep_test();
        nack_test();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- sim.f
source/eeprom_pkg.sv
source/eeprom_ifs.sv
source/req_queue.sv
source/bus_condition.sv
source/byte_shifter.sv
source/eeprom_sequencer.sv
source/eeprom_ctrl_top.sv
verif/eeprom_model.sv
verif/tb_eeprom_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
